// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --assert -Wno-fatal
TOP = cpuTb
FILELIST = src.f
OBJDIR = obj_dir
SIM = $(OBJDIR)/V$(TOP)
LOG = sim.log
SRCS = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: alu.sv
`timescale 1ns/1ns

module alu (
    input  cpuPkg::aluOpT op,
    input  logic [cpuPkg::dataW-1:0] a,
    input  logic [cpuPkg::dataW-1:0] b,
    output logic [cpuPkg::dataW-1:0] y
);
    import cpuPkg::*;

    logic [shW-1:0] shAmt;
    logic [2*dataW-1:0] rotL;
    logic [2*dataW-1:0] rotR;

    // Only the low five bits shift
    assign shAmt = b[shW-1:0];

    // Rotates from a doubled word
    assign rotL = {a, a} << shAmt;
    assign rotR = {a, a} >> shAmt;

    always_comb begin
        case (op)
            aluAdd: y = a + b;
            aluSub: y = a - b;
            aluAnd: y = a & b;
            aluOr: y = a | b;
            aluSll: y = a << shAmt;
            aluSrl: y = a >> shAmt;
            aluSra: y = $signed(a) >>> shAmt;
            aluRol: y = rotL[2*dataW-1:dataW];
            aluRor: y = rotR[dataW-1:0];
            // Unary ops act on a alone
            aluNeg: y = -a;
            aluNot: y = ~a;
            default: y = a + b;
        endcase
    end

endmodule

// File: cpuControl.sv
`timescale 1ns/1ns

module cpuControl (
    input  logic iClk,
    input  logic nRst,
    output cpuPkg::wbMasterT wbM,
    input  cpuPkg::wbSlaveT wbS,
    input  logic [cpuPkg::dataW-1:0] memAdr,
    input  logic [cpuPkg::dataW-1:0] memDat,
    input  cpuPkg::flagsT flags,
    output cpuPkg::ctrlT ctrl,
    output logic [cpuPkg::dataW-1:0] imm,
    output logic halted
);
    import cpuPkg::*;

    // Step counter
    logic [stepW-1:0] step;
    logic [stepW-1:0] stepNext;
    logic stepAdv;
    // Instruction register and its fields
    logic [dataW-1:0] ir;
    decodedT dec;
    // Bus strobes, registered
    logic busCyc;
    logic busWe;
    logic busAck;
    // Opcode classes
    logic fmtR;
    logic fmtI;
    logic isLd;
    logic isSt;
    logic isBr;
    logic isJal;
    logic isJfr;
    logic isOut;
    logic isHlt;
    logic memAcc;
    logic writesReg;
    aluOpT aluOp;
    // Branch evaluation
    brCondT brCond;
    logic condMet;
    logic brTaken;
    logic haltNow;

    // Ack only counts during our own cycle
    assign busAck = wbS.ack & busCyc;
    assign memAcc = isLd | isSt;
    assign haltNow = step[stepWrite] & isHlt;

    // Fetch and data access wait for ack, all else is one cycle
    assign stepAdv = (step[stepFetch] | (step[stepMem] & memAcc)) ? busAck : 1'b1;
    assign stepNext = stepAdv ? {step[stepW-2:0], step[stepW-1]} : step;

    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            step <= stepW'(1) << stepFetch;
            busCyc <= 1'b0;
            busWe <= 1'b0;
            halted <= 1'b0;
        end else begin
            step <= stepNext;
            // Request the bus for the step being entered
            // No new fetch once HLT has retired
            busCyc <= (stepNext[stepFetch] & ~haltNow & ~halted) | (stepNext[stepMem] & memAcc);
            busWe <= stepNext[stepMem] & isSt;
            if (haltNow) begin
                halted <= 1'b1;
            end
        end
    end

    // IR captured on the fetch ack
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            ir <= '0;
        end else if (step[stepFetch] && busAck) begin
            ir <= wbS.datIn;
        end
    end

    instrDecoder uDecoder (
        .instr(ir),
        .dec(dec)
    );

    // Format and ALU op from the opcode
    always_comb begin
        fmtR = 1'b0;
        fmtI = 1'b0;
        isLd = 1'b0;
        isSt = 1'b0;
        isBr = 1'b0;
        isJal = 1'b0;
        isJfr = 1'b0;
        isOut = 1'b0;
        isHlt = 1'b0;
        aluOp = aluAdd;
        case (dec.opcode)
            opAdd: fmtR = 1'b1;
            opSub: begin
                fmtR = 1'b1;
                aluOp = aluSub;
            end
            opAnd, opAndi: begin
                fmtR = (dec.opcode == opAnd);
                fmtI = (dec.opcode == opAndi);
                aluOp = aluAnd;
            end
            opOr, opOri: begin
                fmtR = (dec.opcode == opOr);
                fmtI = (dec.opcode == opOri);
                aluOp = aluOr;
            end
            opSll: begin
                fmtR = 1'b1;
                aluOp = aluSll;
            end
            opSrl: begin
                fmtR = 1'b1;
                aluOp = aluSrl;
            end
            opSra: begin
                fmtR = 1'b1;
                aluOp = aluSra;
            end
            opRol: begin
                fmtR = 1'b1;
                aluOp = aluRol;
            end
            opRor: begin
                fmtR = 1'b1;
                aluOp = aluRor;
            end
            opNeg: begin
                fmtI = 1'b1;
                aluOp = aluNeg;
            end
            opNot: begin
                fmtI = 1'b1;
                aluOp = aluNot;
            end
            // Address or LI value is rb plus constant
            opAddi, opLi: fmtI = 1'b1;
            opLd: begin
                fmtI = 1'b1;
                isLd = 1'b1;
            end
            opSt: begin
                fmtI = 1'b1;
                isSt = 1'b1;
            end
            opBr: isBr = 1'b1;
            opJal: isJal = 1'b1;
            opJfr: isJfr = 1'b1;
            opOut: isOut = 1'b1;
            opHlt: isHlt = 1'b1;
            default: aluOp = aluAdd;
        endcase
    end

    assign writesReg = fmtR | (fmtI & ~isSt) | isJal;

    // Flags come from the B operand, loaded from ra for BRx
    assign brCond = brCondT'(dec.rc[1:0]);

    always_comb begin
        case (brCond)
            brZero: condMet = flags.zero;
            brNonZero: condMet = flags.nonZero;
            brPos: condMet = flags.pos;
            default: condMet = flags.neg;
        endcase
    end

    assign brTaken = isBr & condMet;

    // Branch offset replaces the immediate for BRx
    assign imm = isBr ? dec.brOff32 : dec.imm32;

    // Datapath control from format and step
    always_comb begin
        ctrl.pcInc = step[stepFetch] & busAck;
        ctrl.pcLoadRa = step[stepExec] & (isJal | isJfr);
        ctrl.pcAddOff = step[stepExec] & brTaken;
        ctrl.opLoad = step[stepDecode];
        // LD fills res from the bus instead of the ALU
        ctrl.resLoad = (step[stepExec] & ~isLd) | (step[stepMem] & isLd & busAck);
        ctrl.rfWrite = step[stepWrite] & writesReg;
        ctrl.portLoad = step[stepMem] & isOut;
        ctrl.madrLoad = step[stepExec] & memAcc;
        // MiniSRC writes ra, sources rb and rc
        ctrl.rfAddrA = (fmtR | fmtI) ? dec.rb : dec.ra;
        // Store data, branch test and jump target all name ra
        ctrl.rfAddrB = fmtR ? dec.rc : dec.ra;
        ctrl.rfAddrW = isJal ? regAddrW'(linkReg) : dec.ra;
        ctrl.aluOp = aluOp;
        ctrl.bSelImm = fmtI;
        ctrl.wbSelMem = isLd;
        ctrl.wbSelPc = isJal;
        ctrl.addrSelData = step[stepMem] & memAcc;
    end

    // Wishbone master, stb follows cyc for single transfers
    always_comb begin
        wbM.cyc = busCyc;
        wbM.stb = busCyc;
        wbM.we = busWe;
        wbM.adr = memAdr;
        wbM.datOut = memDat;
    end

endmodule

// File: cpuPkg.sv
package cpuPkg;

    // Bus and register widths
    localparam int dataW = 32;
    localparam int regAddrW = 4;
    localparam int shW = $clog2(dataW);
    // JAL writes its return address here
    localparam int linkReg = 15;

    // MiniSRC field positions
    localparam int opLsb = 27;
    localparam int raLsb = 23;
    localparam int rbLsb = 19;
    localparam int rcLsb = 15;
    // Constant widths before sign extension
    localparam int immW = 19;
    localparam int brOffW = 15;

    // One-hot step bits
    localparam int stepW = 5;
    localparam int stepFetch = 0;
    localparam int stepDecode = 1;
    localparam int stepExec = 2;
    localparam int stepMem = 3;
    localparam int stepWrite = 4;

    typedef enum logic [4:0] {
        opLd = 5'h00,
        opLi = 5'h01,
        opSt = 5'h02,
        opAdd = 5'h03,
        opSub = 5'h04,
        opAnd = 5'h05,
        opOr = 5'h06,
        opRor = 5'h07,
        opRol = 5'h08,
        opSrl = 5'h09,
        opSra = 5'h0a,
        opSll = 5'h0b,
        opAddi = 5'h0c,
        opAndi = 5'h0d,
        opOri = 5'h0e,
        opNeg = 5'h11,
        opNot = 5'h12,
        opBr = 5'h13,
        opJfr = 5'h14,
        opJal = 5'h15,
        opOut = 5'h17,
        opNop = 5'h1a,
        opHlt = 5'h1b
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSll,
        aluSrl,
        aluSra,
        aluRol,
        aluRor,
        aluNeg,
        aluNot
    } aluOpT;

    // Held in the low two bits of rc
    typedef enum logic [1:0] {
        brZero,
        brNonZero,
        brPos,
        brNeg
    } brCondT;

    typedef struct packed {
        opcodeT opcode;
        logic [regAddrW-1:0] ra;
        logic [regAddrW-1:0] rb;
        logic [regAddrW-1:0] rc;
        logic [dataW-1:0] imm32;
        logic [dataW-1:0] brOff32;
    } decodedT;

    typedef struct packed {
        // Register enables
        logic pcInc;
        logic pcLoadRa;
        logic pcAddOff;
        logic opLoad;
        logic resLoad;
        logic rfWrite;
        logic portLoad;
        logic madrLoad;
        // Register file addresses
        logic [regAddrW-1:0] rfAddrA;
        logic [regAddrW-1:0] rfAddrB;
        logic [regAddrW-1:0] rfAddrW;
        // ALU control
        aluOpT aluOp;
        logic bSelImm;
        // Result source and bus address source
        logic wbSelMem;
        logic wbSelPc;
        logic addrSelData;
    } ctrlT;

    typedef struct packed {
        logic zero;
        logic nonZero;
        logic pos;
        logic neg;
    } flagsT;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [dataW-1:0] adr;
        logic [dataW-1:0] datOut;
    } wbMasterT;

    typedef struct packed {
        logic ack;
        logic [dataW-1:0] datIn;
    } wbSlaveT;

endpackage

// File: cpuProperties.sv
`timescale 1ns/1ns

module cpuProperties (
    input logic iClk,
    input logic nRst,
    input cpuPkg::wbMasterT wbM,
    input cpuPkg::wbSlaveT wbS,
    input logic [cpuPkg::stepW-1:0] step,
    input cpuPkg::ctrlT ctrl
);
    import cpuPkg::*;

    // Single transfers, cyc and stb drop right after ack
    endAfterAck: assert property (@(posedge iClk) disable iff (!nRst)
        (wbM.stb && wbS.ack) |=> (!wbM.cyc && !wbM.stb))
        else $error("cyc or stb still high after ack");

    // Request held until the slave acks
    reqStable: assert property (@(posedge iClk) disable iff (!nRst)
        (wbM.stb && !wbS.ack) |=> ($stable(wbM.adr) && $stable(wbM.we)))
        else $error("adr or we changed while waiting for ack");

    stepOneHot: assert property (@(posedge iClk) disable iff (!nRst) $onehot(step))
        else $error("step register is not one-hot");

    // Register file written only in the last step, right after mem, bus idle
    wrInWrite: assert property (@(posedge iClk) disable iff (!nRst)
        ctrl.rfWrite |-> (step[stepWrite] && $past(step[stepMem]) && !wbM.cyc))
        else $error("rfWrite outside the write step");

endmodule

bind cpuControl cpuProperties uProps (
    .iClk(iClk),
    .nRst(nRst),
    .wbM(wbM),
    .wbS(wbS),
    .step(step),
    .ctrl(ctrl)
);

// File: cpuTb.sv
`timescale 1ns/1ns

module cpuTb;
    import cpuPkg::*;

    logic iClk;
    logic nRst;
    wbMasterT wbM;
    wbSlaveT wbS;
    logic [dataW-1:0] portData;
    logic portValid;
    logic halted;

    // Memory model state
    logic [dataW-1:0] mem [64];
    logic inXfer;
    int waitLeft;
    // Program image, expected OUT values, expected store
    logic [dataW-1:0] prog [$];
    logic [dataW-1:0] expOut [$];
    logic [dataW-1:0] expStoreAdr;
    logic [dataW-1:0] expStoreData;
    int outCount;

    cpuTop dut0 (
        .iClk(iClk),
        .nRst(nRst),
        .wbM(wbM),
        .wbS(wbS),
        .portData(portData),
        .portValid(portValid),
        .halted(halted)
    );

    always #50 iClk = ~iClk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [dataW-1:0] got,
                              input logic [dataW-1:0] exp);
        if (got !== exp) begin
            failRun($sformatf("Error: %s expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    // MiniSRC instruction formats
    function automatic logic [dataW-1:0] regInstr(opcodeT op, int ra, int rb, int rc);
        return {op, 4'(ra), 4'(rb), 4'(rc), 15'd0};
    endfunction

    function automatic logic [dataW-1:0] immInstr(opcodeT op, int ra, int rb, int imm);
        return {op, 4'(ra), 4'(rb), 19'(imm)};
    endfunction

    // Condition in the low two bits of rc, offset below it
    function automatic logic [dataW-1:0] branchInstr(int ra, brCondT cond, int off);
        return {opBr, 4'(ra), 4'd0, 2'b00, cond, 15'(off)};
    endfunction

    task automatic buildTables();
        logic [dataW-1:0] v1;
        logic [dataW-1:0] v2;
        logic [dataW-1:0] v3;
        int subAdr;
        v1 = 32'h0000_1234;
        v2 = 32'hffff_ff00;
        v3 = 32'd3;
        expStoreAdr = 32'd60;
        expStoreData = v2;
        // r1, r2, r3 set up by ADDI, r2 from a negative constant
        prog.push_back(immInstr(opAddi, 1, 0, 'h1234));
        prog.push_back(immInstr(opAddi, 2, 0, -256));
        prog.push_back(immInstr(opAddi, 3, 0, 3));
        // Each ALU result goes to r4 and out
        prog.push_back(regInstr(opAdd, 4, 1, 2));
        expOut.push_back(v1 + v2);
        prog.push_back(regInstr(opSub, 4, 1, 3));
        expOut.push_back(v1 - v3);
        prog.push_back(regInstr(opAnd, 4, 1, 2));
        expOut.push_back(v1 & v2);
        prog.push_back(regInstr(opOr, 4, 1, 3));
        expOut.push_back(v1 | v3);
        prog.push_back(regInstr(opSll, 4, 1, 3));
        expOut.push_back(v1 << 3);
        prog.push_back(regInstr(opSrl, 4, 2, 3));
        expOut.push_back(v2 >> 3);
        prog.push_back(regInstr(opSra, 4, 2, 3));
        expOut.push_back({{3{v2[31]}}, v2[31:3]});
        prog.push_back(regInstr(opRol, 4, 2, 3));
        expOut.push_back((v2 << 3) | (v2 >> 29));
        prog.push_back(regInstr(opRor, 4, 1, 3));
        expOut.push_back((v1 >> 3) | (v1 << 29));
        prog.push_back(immInstr(opNeg, 4, 1, 0));
        expOut.push_back(~v1 + 32'd1);
        prog.push_back(immInstr(opNot, 4, 1, 0));
        expOut.push_back(~v1);
        // Interleave the OUT after every ALU op
        for (int i = 14; i >= 4; i--) begin
            prog.insert(i, immInstr(opOut, 4, 0, 0));
        end
        // Store r2 at r3 + 57, load it back into r5
        prog.push_back(immInstr(opSt, 2, 3, 57));
        prog.push_back(immInstr(opLd, 5, 0, 60));
        prog.push_back(immInstr(opOut, 5, 0, 0));
        expOut.push_back(v2);
        // Write to r0 must be lost
        prog.push_back(immInstr(opAddi, 0, 1, 5));
        prog.push_back(immInstr(opOut, 0, 0, 0));
        expOut.push_back(32'd0);
        // Taken branch skips an OUT, not-taken one falls through to an OUT
        prog.push_back(branchInstr(0, brZero, 1));
        prog.push_back(immInstr(opOut, 2, 0, 0));
        prog.push_back(branchInstr(1, brZero, 1));
        prog.push_back(immInstr(opOut, 3, 0, 0));
        expOut.push_back(v3);
        prog.push_back(branchInstr(1, brNonZero, 1));
        prog.push_back(immInstr(opOut, 2, 0, 0));
        prog.push_back(branchInstr(0, brNonZero, 1));
        prog.push_back(immInstr(opOut, 1, 0, 0));
        expOut.push_back(v1);
        prog.push_back(branchInstr(1, brPos, 1));
        prog.push_back(immInstr(opOut, 2, 0, 0));
        prog.push_back(branchInstr(2, brPos, 1));
        prog.push_back(immInstr(opOut, 4, 0, 0));
        expOut.push_back(~v1);
        prog.push_back(branchInstr(2, brNeg, 1));
        prog.push_back(immInstr(opOut, 1, 0, 0));
        prog.push_back(branchInstr(1, brNeg, 1));
        prog.push_back(immInstr(opOut, 5, 0, 0));
        expOut.push_back(v2);
        // Call sits after ADDI, JAL, OUT r15 and HLT
        subAdr = prog.size() + 4;
        prog.push_back(immInstr(opAddi, 6, 0, subAdr));
        prog.push_back(immInstr(opJal, 6, 0, 0));
        prog.push_back(immInstr(opOut, 15, 0, 0));
        prog.push_back(immInstr(opHlt, 0, 0, 0));
        // Subroutine body
        prog.push_back(immInstr(opOut, 6, 0, 0));
        prog.push_back(immInstr(opJfr, 15, 0, 0));
        expOut.push_back(32'(subAdr));
        // Link is the word after JAL
        expOut.push_back(32'(subAdr - 2));
    endtask

    // Wishbone slave with 0 to 3 wait states per transfer
    always @(negedge iClk) begin
        if (wbS.ack) begin
            wbS.ack = 1'b0;
            inXfer = 1'b0;
        end else if (nRst && wbM.cyc && wbM.stb) begin
            if (!inXfer) begin
                inXfer = 1'b1;
                waitLeft = int'($urandom % 32'd4);
            end
            if (waitLeft == 0) begin
                if (wbM.adr[dataW-1:6] != '0) begin
                    failRun("Bus address lies outside the 64-word memory");
                end
                if (wbM.we) begin
                    checkValue("wbM.adr", wbM.adr, expStoreAdr);
                    checkValue("wbM.datOut", wbM.datOut, expStoreData);
                    mem[wbM.adr[5:0]] = wbM.datOut;
                end else begin
                    wbS.datIn = mem[wbM.adr[5:0]];
                end
                wbS.ack = 1'b1;
            end else begin
                waitLeft--;
            end
        end
    end

    // Count every OUT strobe
    always @(negedge iClk) begin
        if (nRst && portValid) begin
            outCount++;
        end
    end

    task automatic nextOut(input int idx);
        int n;
        n = 0;
        do begin
            @(negedge iClk);
            n++;
        end while (!portValid && n < 200);
        if (!portValid) begin
            failRun($sformatf("portValid never rose for OUT number %0d", idx));
        end
    endtask

    task automatic expectHalt();
        int n;
        n = 0;
        while (!halted && n < 200) begin
            @(negedge iClk);
            n++;
        end
        if (!halted) begin
            failRun("halted never rose after the last OUT");
        end
    endtask

    task automatic watchBusIdle();
        for (int n = 0; n < 20; n++) begin
            @(negedge iClk);
            if (wbM.cyc) begin
                failRun("A bus cycle started after the core halted");
            end
        end
    endtask

    initial begin
        iClk = 1'b0;
        nRst = 1'b0;
        wbS = '0;
        inXfer = 1'b0;
        waitLeft = 0;
        outCount = 0;
        void'($urandom(32'hd6a4cf76));
        buildTables();
        // Unused words decode as HLT
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'hdead_0000 | 32'(i);
        end
        for (int i = 0; i < prog.size(); i++) begin
            mem[i] = prog[i];
        end
        repeat (10) @(negedge iClk);
        nRst = 1'b1;
        for (int i = 0; i < expOut.size(); i++) begin
            nextOut(i);
            checkValue("portData", portData, expOut[i]);
        end
        expectHalt();
        watchBusIdle();
        // No skipped OUT slipped through
        checkValue("outCount", 32'(outCount), 32'(expOut.size()));
        $display("Test OK");
        $finish;
    end

endmodule

// File: cpuTop.sv
`timescale 1ns/1ns

module cpuTop (
    input  logic iClk,
    input  logic nRst,
    output cpuPkg::wbMasterT wbM,
    input  cpuPkg::wbSlaveT wbS,
    output logic [cpuPkg::dataW-1:0] portData,
    output logic portValid,
    output logic halted
);
    import cpuPkg::*;

    ctrlT ctrl;
    flagsT flags;
    logic [dataW-1:0] imm;
    logic [dataW-1:0] memAdr;
    logic [dataW-1:0] memDat;

    cpuControl uControl (
        .iClk(iClk),
        .nRst(nRst),
        .wbM(wbM),
        .wbS(wbS),
        .memAdr(memAdr),
        .memDat(memDat),
        .flags(flags),
        .ctrl(ctrl),
        .imm(imm),
        .halted(halted)
    );

    // LD data taken straight from the slave
    dataPath uDataPath (
        .iClk(iClk),
        .nRst(nRst),
        .ctrl(ctrl),
        .imm(imm),
        .memRdData(wbS.datIn),
        .memAdr(memAdr),
        .memDat(memDat),
        .flags(flags),
        .portData(portData),
        .portValid(portValid)
    );

endmodule

// File: dataPath.sv
`timescale 1ns/1ns

module dataPath (
    input  logic iClk,
    input  logic nRst,
    input  cpuPkg::ctrlT ctrl,
    input  logic [cpuPkg::dataW-1:0] imm,
    input  logic [cpuPkg::dataW-1:0] memRdData,
    output logic [cpuPkg::dataW-1:0] memAdr,
    output logic [cpuPkg::dataW-1:0] memDat,
    output cpuPkg::flagsT flags,
    output logic [cpuPkg::dataW-1:0] portData,
    output logic portValid
);
    import cpuPkg::*;

    logic [dataW-1:0] pc;
    // Operand registers
    logic [dataW-1:0] opA;
    logic [dataW-1:0] opB;
    logic [dataW-1:0] res;
    logic [dataW-1:0] resNext;
    logic [dataW-1:0] madr;
    logic [dataW-1:0] rdA;
    logic [dataW-1:0] rdB;
    logic [dataW-1:0] aluB;
    logic [dataW-1:0] aluY;

    // Write-back always comes from res
    regFile uRegFile (
        .iClk(iClk),
        .nRst(nRst),
        .addrA(ctrl.rfAddrA),
        .addrB(ctrl.rfAddrB),
        .addrW(ctrl.rfAddrW),
        .wrEn(ctrl.rfWrite),
        .wrData(res),
        .rdA(rdA),
        .rdB(rdB)
    );

    assign aluB = ctrl.bSelImm ? imm : opB;

    alu uAlu (
        .op(ctrl.aluOp),
        .a(opA),
        .b(aluB),
        .y(aluY)
    );

    // Word-addressed pc, offset is relative to pc+1
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            pc <= '0;
        end else if (ctrl.pcInc) begin
            pc <= pc + 1'b1;
        end else if (ctrl.pcLoadRa) begin
            pc <= opA;
        end else if (ctrl.pcAddOff) begin
            pc <= pc + imm;
        end
    end

    // Loaded data, link address or ALU result into res
    assign resNext = ctrl.wbSelMem ? memRdData : (ctrl.wbSelPc ? pc : aluY);

    always_ff @(posedge iClk) begin
        if (ctrl.opLoad) begin
            opA <= rdA;
            opB <= rdB;
        end
        if (ctrl.resLoad) begin
            res <= resNext;
        end
        if (ctrl.madrLoad) begin
            madr <= aluY;
        end
        if (ctrl.portLoad) begin
            portData <= opA;
        end
    end

    // One-cycle strobe per OUT
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            portValid <= 1'b0;
        end else begin
            portValid <= ctrl.portLoad;
        end
    end

    assign memAdr = ctrl.addrSelData ? madr : pc;
    // Store data is the ra operand
    assign memDat = opB;

    // Branch flags on the tested register
    assign flags.zero = (opB == '0);
    assign flags.nonZero = (opB != '0);
    assign flags.pos = ~opB[dataW-1] & (opB != '0);
    assign flags.neg = opB[dataW-1];

endmodule

// File: instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder (
    input  logic [cpuPkg::dataW-1:0] instr,
    output cpuPkg::decodedT dec
);
    import cpuPkg::*;

    always_comb begin
        // Opcode in the top five bits
        dec.opcode = opcodeT'(instr[opLsb +: $bits(opcodeT)]);

        // Register fields
        // ra is the destination, and the tested register for BRx
        dec.ra = instr[raLsb +: regAddrW];
        dec.rb = instr[rbLsb +: regAddrW];
        // Third source for R format, branch condition in low bits
        dec.rc = instr[rcLsb +: regAddrW];

        // 19-bit constant for I format
        dec.imm32 = {{(dataW - immW){instr[immW-1]}}, instr[immW-1:0]};

        // Branch offset sits below the rc field
        // Relative to the already incremented pc
        dec.brOff32 = {{(dataW - brOffW){instr[brOffW-1]}}, instr[brOffW-1:0]};
    end

endmodule

// File: regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic iClk,
    input  logic nRst,
    input  logic [cpuPkg::regAddrW-1:0] addrA,
    input  logic [cpuPkg::regAddrW-1:0] addrB,
    input  logic [cpuPkg::regAddrW-1:0] addrW,
    input  logic wrEn,
    input  logic [cpuPkg::dataW-1:0] wrData,
    output logic [cpuPkg::dataW-1:0] rdA,
    output logic [cpuPkg::dataW-1:0] rdB
);
    import cpuPkg::*;

    logic [dataW-1:0] regs [2**regAddrW];

    // r0 is never written
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            for (int i = 0; i < 2**regAddrW; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (addrW != '0)) begin
            regs[addrW] <= wrData;
        end
    end

    // Combinational reads, r0 forced to zero
    assign rdA = (addrA == '0) ? '0 : regs[addrA];
    assign rdB = (addrB == '0) ? '0 : regs[addrB];

endmodule

// File: src.f
cpuPkg.sv
instrDecoder.sv
regFile.sv
alu.sv
cpuControl.sv
dataPath.sv
cpuTop.sv
cpuProperties.sv
cpuTb.sv
